// File: hw/mips_id_pkg.sv
package mips_id_pkg;

	parameter int XLEN       = 32;
	parameter int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	////////////////////////////////////////////////////////////////////////////
	// instruction fields
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_REGIMM  = 6'h01,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_BLEZ    = 6'h06,
		OP_BGTZ    = 6'h07,
		OP_ADDI    = 6'h08,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_SLTIU   = 6'h0b,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f,
		OP_LB      = 6'h20,
		OP_LH      = 6'h21,
		OP_LW      = 6'h23,
		OP_LBU     = 6'h24,
		OP_LHU     = 6'h25,
		OP_SB      = 6'h28,
		OP_SH      = 6'h29,
		OP_SW      = 6'h2b
	} opcode_t;

	// function field of SPECIAL
	typedef enum logic [5:0] {
		FN_SLL     = 6'h00,
		FN_SRL     = 6'h02,
		FN_SRA     = 6'h03,
		FN_SLLV    = 6'h04,
		FN_SRLV    = 6'h06,
		FN_SRAV    = 6'h07,
		FN_JR      = 6'h08,
		FN_JALR    = 6'h09,
		FN_SYSCALL = 6'h0c,
		FN_BREAK   = 6'h0d,
		FN_MTHI    = 6'h11,
		FN_MTLO    = 6'h13,
		FN_MULT    = 6'h18,
		FN_MULTU   = 6'h19,
		FN_DIV     = 6'h1a,
		FN_DIVU    = 6'h1b,
		FN_ADD     = 6'h20,
		FN_ADDU    = 6'h21,
		FN_SUB     = 6'h22,
		FN_SUBU    = 6'h23,
		FN_AND     = 6'h24,
		FN_OR      = 6'h25,
		FN_XOR     = 6'h26,
		FN_NOR     = 6'h27,
		FN_SLT     = 6'h2a,
		FN_SLTU    = 6'h2b
	} funct_t;

	typedef enum logic [4:0] {
		RI_BLTZ   = 5'h00,
		RI_BGEZ   = 5'h01,
		RI_BLTZAL = 5'h10,
		RI_BGEZAL = 5'h11
	} regimm_t;

	////////////////////////////////////////////////////////////////////////////
	// decode results
	////////////////////////////////////////////////////////////////////////////

	typedef logic [5:0] alu_op_t; // otherwise funct or opcode of the instruction

	parameter alu_op_t ALU_ADD  = 6'b001001;
	parameter alu_op_t ALU_NONE = 6'b111111; // no alu work

	typedef enum logic [1:0] {SRC1_REG, SRC1_PC, SRC1_SA} src1_sel_t;
	typedef enum logic [1:0] {SRC2_REG, SRC2_SIMM, SRC2_ZIMM, SRC2_LINK} src2_sel_t;
	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_t;

	parameter reg_addr_t LINK_REG    = 5'd31;
	parameter word_t     LINK_OFFSET = 32'd8; // return address past the delay slot

endpackage

// File: hw/id_select_if.sv
`timescale 1ns/1ps

// operand routing, decoder to operand select
interface id_select_if;

	mips_id_pkg::src1_sel_t src1_sel;
	mips_id_pkg::src2_sel_t src2_sel;
	logic                   rs_used; // read port 1 needed
	logic                   rt_used; // read port 2 needed

	modport decoder (
		output src1_sel,
		output src2_sel,
		output rs_used,
		output rt_used
	);

	modport selector (
		input src1_sel,
		input src2_sel,
		input rs_used,
		input rt_used
	);

endinterface

// File: hw/id_latch.sv
`timescale 1ns/1ps

module id_latch #(
	parameter mips_id_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               stall,
	input  logic               clear,
	input  mips_id_pkg::word_t if_pc,
	input  logic               if_delay_slot,
	input  mips_id_pkg::word_t cache_inst,
	input  logic               cache_inst_valid,
	output logic               cache_inst_ack,
	output mips_id_pkg::word_t pc,
	output mips_id_pkg::word_t inst,
	output logic               delay_slot
);

	// no room while stalled, clearing or in reset
	assign cache_inst_ack = rst_n && !stall && !clear;

	always_ff @(posedge clk) begin
		if (!rst_n || clear) begin
			pc         <= RESET_PC;
			inst       <= '0;
			delay_slot <= 1'b0;
		end else if (cache_inst_valid && cache_inst_ack) begin
			pc         <= if_pc;
			inst       <= cache_inst;
			delay_slot <= if_delay_slot;
		end
		// otherwise hold
	end

endmodule

// File: hw/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
	input  mips_id_pkg::word_t      inst,
	id_select_if.decoder            sel,
	output mips_id_pkg::alu_op_t    alu_op,
	output mips_id_pkg::reg_addr_t  dest,
	output logic                    is_unsigned,
	output logic                    is_mult,
	output logic                    is_div,
	output logic                    is_load,
	output logic                    is_store,
	output mips_id_pkg::mem_size_t  mem_size,
	output logic                    load_unsigned,
	output logic                    branch,
	output logic                    br_eq,
	output logic                    br_ne,
	output logic                    br_gtz_or_gez,
	output logic                    br_eq_zero,
	output logic                    br_ltz_or_lez,
	output logic                    jump,
	output logic                    jump_reg,
	output logic                    delay,
	output logic                    mthi,
	output logic                    mtlo,
	output logic                    syscall,
	output logic                    brk,
	output logic                    no_inst,
	output logic                    go_mem,
	output logic                    go_wb
);

	mips_id_pkg::opcode_t   op;
	mips_id_pkg::funct_t    fn;
	mips_id_pkg::regimm_t   ri;
	mips_id_pkg::reg_addr_t rt;
	mips_id_pkg::reg_addr_t rd;
	logic special, sa_zero, rs_zero, rt_zero, md_zero, hi_zero;

	logic ins_add, ins_addu, ins_sub, ins_subu, ins_slt, ins_sltu;
	logic ins_addi, ins_addiu, ins_slti, ins_sltiu;
	logic ins_mult, ins_multu, ins_div, ins_divu;
	logic ins_and, ins_or, ins_xor, ins_nor, ins_andi, ins_ori, ins_xori, ins_lui;
	logic ins_sll, ins_srl, ins_sra, ins_sllv, ins_srlv, ins_srav;
	logic ins_beq, ins_bne, ins_blez, ins_bgtz;
	logic ins_bltz, ins_bgez, ins_bltzal, ins_bgezal;
	logic ins_j, ins_jal, ins_jr, ins_jalr;
	logic ins_lb, ins_lbu, ins_lh, ins_lhu, ins_lw, ins_sb, ins_sh, ins_sw;

	logic arith_r, arith_i, logic_r, logic_i, shift_c, shift, muldiv;
	logic alu_r, alu_i, regimm_br, br_link;

	assign op = mips_id_pkg::opcode_t'(inst[31:26]);
	assign fn = mips_id_pkg::funct_t'(inst[5:0]);
	assign ri = mips_id_pkg::regimm_t'(inst[20:16]);
	assign rt = inst[20:16];
	assign rd = inst[15:11];

	assign special = op == mips_id_pkg::OP_SPECIAL;
	assign sa_zero = inst[10:6] == 5'd0;
	assign rs_zero = inst[25:21] == 5'd0;
	assign rt_zero = rt == 5'd0;
	assign md_zero = inst[15:6] == 10'd0; // rd and sa
	assign hi_zero = inst[20:6] == 15'd0; // rt, rd and sa

	////////////////////////////////////////////////////////////////////////////
	// recognition
	////////////////////////////////////////////////////////////////////////////

	assign ins_add   = special && sa_zero && fn == mips_id_pkg::FN_ADD;
	assign ins_addu  = special && sa_zero && fn == mips_id_pkg::FN_ADDU;
	assign ins_sub   = special && sa_zero && fn == mips_id_pkg::FN_SUB;
	assign ins_subu  = special && sa_zero && fn == mips_id_pkg::FN_SUBU;
	assign ins_slt   = special && sa_zero && fn == mips_id_pkg::FN_SLT;
	assign ins_sltu  = special && sa_zero && fn == mips_id_pkg::FN_SLTU;
	assign ins_and   = special && sa_zero && fn == mips_id_pkg::FN_AND;
	assign ins_or    = special && sa_zero && fn == mips_id_pkg::FN_OR;
	assign ins_xor   = special && sa_zero && fn == mips_id_pkg::FN_XOR;
	assign ins_nor   = special && sa_zero && fn == mips_id_pkg::FN_NOR;
	assign ins_sllv  = special && sa_zero && fn == mips_id_pkg::FN_SLLV;
	assign ins_srlv  = special && sa_zero && fn == mips_id_pkg::FN_SRLV;
	assign ins_srav  = special && sa_zero && fn == mips_id_pkg::FN_SRAV;
	assign ins_sll   = special && rs_zero && fn == mips_id_pkg::FN_SLL; // also nop
	assign ins_srl   = special && rs_zero && fn == mips_id_pkg::FN_SRL;
	assign ins_sra   = special && rs_zero && fn == mips_id_pkg::FN_SRA;
	assign ins_mult  = special && md_zero && fn == mips_id_pkg::FN_MULT;
	assign ins_multu = special && md_zero && fn == mips_id_pkg::FN_MULTU;
	assign ins_div   = special && md_zero && fn == mips_id_pkg::FN_DIV;
	assign ins_divu  = special && md_zero && fn == mips_id_pkg::FN_DIVU;
	assign ins_jr    = special && hi_zero && fn == mips_id_pkg::FN_JR;
	assign ins_jalr  = special && rt_zero && sa_zero && fn == mips_id_pkg::FN_JALR;
	assign mthi      = special && hi_zero && fn == mips_id_pkg::FN_MTHI;
	assign mtlo      = special && hi_zero && fn == mips_id_pkg::FN_MTLO;
	assign syscall   = special && fn == mips_id_pkg::FN_SYSCALL; // code field is free
	assign brk       = special && fn == mips_id_pkg::FN_BREAK;

	assign ins_addi  = op == mips_id_pkg::OP_ADDI;
	assign ins_addiu = op == mips_id_pkg::OP_ADDIU;
	assign ins_slti  = op == mips_id_pkg::OP_SLTI;
	assign ins_sltiu = op == mips_id_pkg::OP_SLTIU;
	assign ins_andi  = op == mips_id_pkg::OP_ANDI;
	assign ins_ori   = op == mips_id_pkg::OP_ORI;
	assign ins_xori  = op == mips_id_pkg::OP_XORI;
	assign ins_lui   = op == mips_id_pkg::OP_LUI && rs_zero;

	assign ins_beq    = op == mips_id_pkg::OP_BEQ;
	assign ins_bne    = op == mips_id_pkg::OP_BNE;
	assign ins_blez   = op == mips_id_pkg::OP_BLEZ && rt_zero;
	assign ins_bgtz   = op == mips_id_pkg::OP_BGTZ && rt_zero;
	assign ins_bltz   = op == mips_id_pkg::OP_REGIMM && ri == mips_id_pkg::RI_BLTZ;
	assign ins_bgez   = op == mips_id_pkg::OP_REGIMM && ri == mips_id_pkg::RI_BGEZ;
	assign ins_bltzal = op == mips_id_pkg::OP_REGIMM && ri == mips_id_pkg::RI_BLTZAL;
	assign ins_bgezal = op == mips_id_pkg::OP_REGIMM && ri == mips_id_pkg::RI_BGEZAL;
	assign ins_j      = op == mips_id_pkg::OP_J;
	assign ins_jal    = op == mips_id_pkg::OP_JAL;

	assign ins_lb  = op == mips_id_pkg::OP_LB;
	assign ins_lbu = op == mips_id_pkg::OP_LBU;
	assign ins_lh  = op == mips_id_pkg::OP_LH;
	assign ins_lhu = op == mips_id_pkg::OP_LHU;
	assign ins_lw  = op == mips_id_pkg::OP_LW;
	assign ins_sb  = op == mips_id_pkg::OP_SB;
	assign ins_sh  = op == mips_id_pkg::OP_SH;
	assign ins_sw  = op == mips_id_pkg::OP_SW;

	////////////////////////////////////////////////////////////////////////////
	// classes
	////////////////////////////////////////////////////////////////////////////

	assign arith_r   = ins_add | ins_addu | ins_sub | ins_subu | ins_slt | ins_sltu;
	assign arith_i   = ins_addi | ins_addiu | ins_slti | ins_sltiu;
	assign logic_r   = ins_and | ins_or | ins_xor | ins_nor;
	assign logic_i   = ins_andi | ins_ori | ins_xori | ins_lui;
	assign shift_c   = ins_sll | ins_srl | ins_sra;
	assign shift     = shift_c | ins_sllv | ins_srlv | ins_srav;
	assign muldiv    = ins_mult | ins_multu | ins_div | ins_divu;
	assign alu_r     = arith_r | logic_r | shift;
	assign alu_i     = arith_i | logic_i;
	assign regimm_br = ins_bltz | ins_bgez | ins_bltzal | ins_bgezal;
	assign br_link   = ins_bltzal | ins_bgezal;

	assign is_load  = ins_lb | ins_lbu | ins_lh | ins_lhu | ins_lw;
	assign is_store = ins_sb | ins_sh | ins_sw;
	assign branch   = ins_beq | ins_bne | ins_blez | ins_bgtz | regimm_br;
	assign jump     = ins_j | ins_jal;
	assign jump_reg = ins_jr | ins_jalr;

	assign is_unsigned   = ins_addu | ins_subu | ins_sltu | ins_addiu | ins_sltiu
		| ins_multu | ins_divu;
	assign is_mult       = ins_mult | ins_multu;
	assign is_div        = ins_div | ins_divu;
	assign load_unsigned = ins_lbu | ins_lhu;

	assign br_eq         = ins_beq;
	assign br_ne         = ins_bne;
	assign br_gtz_or_gez = ins_bgez | ins_bgtz | ins_bgezal;
	assign br_eq_zero    = ins_bgez | ins_blez | ins_bgezal;
	assign br_ltz_or_lez = ins_blez | ins_bltz | ins_bltzal;

	assign delay   = branch | jump | jump_reg;
	assign go_mem  = is_load;
	assign go_wb   = alu_r | alu_i | jump | jump_reg | branch;
	assign no_inst = !(alu_r | alu_i | muldiv | branch | jump | jump_reg | is_load
		| is_store | mthi | mtlo | syscall | brk);

	always_comb begin
		if (alu_r)
			alu_op = inst[5:0];
		else if (alu_i)
			alu_op = inst[31:26];
		else if (is_load || is_store || jump_reg)
			alu_op = mips_id_pkg::ALU_ADD; // address or target add
		else
			alu_op = mips_id_pkg::ALU_NONE;
	end

	always_comb begin
		if (alu_r || ins_jalr)
			dest = rd;
		else if (alu_i || is_load)
			dest = rt;
		else if (br_link || ins_jal)
			dest = mips_id_pkg::LINK_REG;
		else
			dest = '0;
	end

	always_comb begin
		if (ins_lb || ins_lbu || ins_sb)
			mem_size = mips_id_pkg::MEM_BYTE;
		else if (ins_lh || ins_lhu || ins_sh)
			mem_size = mips_id_pkg::MEM_HALF;
		else
			mem_size = mips_id_pkg::MEM_WORD;
	end

	// operand routing
	always_comb begin
		if (br_link || ins_jal || ins_jalr)
			sel.src1_sel = mips_id_pkg::SRC1_PC;
		else if (shift_c)
			sel.src1_sel = mips_id_pkg::SRC1_SA;
		else
			sel.src1_sel = mips_id_pkg::SRC1_REG;

		if (is_load || is_store || arith_i)
			sel.src2_sel = mips_id_pkg::SRC2_SIMM;
		else if (logic_i)
			sel.src2_sel = mips_id_pkg::SRC2_ZIMM;
		else if (br_link || ins_jal || ins_jalr)
			sel.src2_sel = mips_id_pkg::SRC2_LINK;
		else
			sel.src2_sel = mips_id_pkg::SRC2_REG; // branches compare registers
	end

	assign sel.rs_used = !(jump | syscall | brk);
	assign sel.rt_used = !(alu_i | regimm_br | jump | is_load | syscall | brk);

endmodule

// File: hw/operand_select.sv
`timescale 1ns/1ps

module operand_select (
	input  mips_id_pkg::word_t     pc,
	input  mips_id_pkg::word_t     inst,
	id_select_if.selector          sel,
	input  mips_id_pkg::word_t     reg_rdata1,
	input  mips_id_pkg::word_t     reg_rdata2,
	output mips_id_pkg::reg_addr_t reg_raddr1,
	output mips_id_pkg::reg_addr_t reg_raddr2,
	output mips_id_pkg::word_t     vsrc1,
	output mips_id_pkg::word_t     vsrc2,
	output mips_id_pkg::word_t     jr_target,
	output logic [25:0]            j_index
);

	localparam int HALF = mips_id_pkg::XLEN / 2;

	// unused ports read r0
	assign reg_raddr1 = sel.rs_used ? inst[25:21] : '0;
	assign reg_raddr2 = sel.rt_used ? inst[20:16] : '0;

	always_comb begin
		case (sel.src1_sel)
			mips_id_pkg::SRC1_REG: vsrc1 = reg_rdata1;
			mips_id_pkg::SRC1_PC:  vsrc1 = pc; // link base
			mips_id_pkg::SRC1_SA:  vsrc1 = {{(mips_id_pkg::XLEN-5){1'b0}}, inst[10:6]};
			default:               vsrc1 = '0;
		endcase
	end

	always_comb begin
		case (sel.src2_sel)
			mips_id_pkg::SRC2_REG:  vsrc2 = reg_rdata2;
			mips_id_pkg::SRC2_SIMM: vsrc2 = {{HALF{inst[15]}}, inst[15:0]};
			mips_id_pkg::SRC2_ZIMM: vsrc2 = {{HALF{1'b0}}, inst[15:0]};
			mips_id_pkg::SRC2_LINK: vsrc2 = mips_id_pkg::LINK_OFFSET;
			default:                vsrc2 = '0;
		endcase
	end

	assign jr_target = reg_rdata1;
	assign j_index   = inst[25:0]; // instr_index for j/jal

endmodule

// File: hw/id_stage.sv
`timescale 1ns/1ps

module id_stage #(
	parameter mips_id_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  logic                   clear,
	input  mips_id_pkg::word_t     if_pc,
	input  logic                   if_delay_slot,
	input  mips_id_pkg::word_t     cache_inst,
	input  logic                   cache_inst_valid,
	output logic                   cache_inst_ack,

	// register file
	output mips_id_pkg::reg_addr_t reg_raddr1,
	output mips_id_pkg::reg_addr_t reg_raddr2,
	input  mips_id_pkg::word_t     reg_rdata1,
	input  mips_id_pkg::word_t     reg_rdata2,

	output mips_id_pkg::word_t     id_pc,
	output mips_id_pkg::word_t     id_inst,
	output logic                   id_delay_slot,

	// decode
	output mips_id_pkg::alu_op_t   alu_op,
	output mips_id_pkg::reg_addr_t dest,
	output logic                   is_unsigned,
	output logic                   is_mult,
	output logic                   is_div,
	output logic                   is_load,
	output logic                   is_store,
	output mips_id_pkg::mem_size_t mem_size,
	output logic                   load_unsigned,
	output logic                   branch,
	output logic                   br_eq,
	output logic                   br_ne,
	output logic                   br_gtz_or_gez,
	output logic                   br_eq_zero,
	output logic                   br_ltz_or_lez,
	output logic                   jump,
	output logic                   jump_reg,
	output logic                   delay,
	output logic                   mthi,
	output logic                   mtlo,
	output logic                   syscall,
	output logic                   brk,
	output logic                   no_inst,
	output logic                   go_mem,
	output logic                   go_wb,

	// operands
	output mips_id_pkg::word_t     vsrc1,
	output mips_id_pkg::word_t     vsrc2,
	output mips_id_pkg::word_t     jr_target,
	output logic [25:0]            j_index
);

	id_select_if sel_if ();

	id_latch #(
		.RESET_PC (RESET_PC)
	) u_latch (
		.clk              (clk),
		.rst_n            (rst_n),
		.stall            (stall),
		.clear            (clear),
		.if_pc            (if_pc),
		.if_delay_slot    (if_delay_slot),
		.cache_inst       (cache_inst),
		.cache_inst_valid (cache_inst_valid),
		.cache_inst_ack   (cache_inst_ack),
		.pc               (id_pc),
		.inst             (id_inst),
		.delay_slot       (id_delay_slot)
	);

	inst_decoder u_decoder (
		.inst          (id_inst),
		.sel           (sel_if),
		.alu_op        (alu_op),
		.dest          (dest),
		.is_unsigned   (is_unsigned),
		.is_mult       (is_mult),
		.is_div        (is_div),
		.is_load       (is_load),
		.is_store      (is_store),
		.mem_size      (mem_size),
		.load_unsigned (load_unsigned),
		.branch        (branch),
		.br_eq         (br_eq),
		.br_ne         (br_ne),
		.br_gtz_or_gez (br_gtz_or_gez),
		.br_eq_zero    (br_eq_zero),
		.br_ltz_or_lez (br_ltz_or_lez),
		.jump          (jump),
		.jump_reg      (jump_reg),
		.delay         (delay),
		.mthi          (mthi),
		.mtlo          (mtlo),
		.syscall       (syscall),
		.brk           (brk),
		.no_inst       (no_inst),
		.go_mem        (go_mem),
		.go_wb         (go_wb)
	);

	operand_select u_select (
		.pc         (id_pc),
		.inst       (id_inst),
		.sel        (sel_if),
		.reg_rdata1 (reg_rdata1),
		.reg_rdata2 (reg_rdata2),
		.reg_raddr1 (reg_raddr1),
		.reg_raddr2 (reg_raddr2),
		.vsrc1      (vsrc1),
		.vsrc2      (vsrc2),
		.jr_target  (jr_target),
		.j_index    (j_index)
	);

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD      = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1; // released just after an edge
	end

	always #(PERIOD / 2) clk = ~clk;

endmodule

// File: dv/id_stage_assertions.sv
`timescale 1ns/1ps

module id_stage_assertions #(
	parameter mips_id_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input logic               clk,
	input logic               rst_n,
	input logic               stall,
	input logic               clear,
	input logic               cache_inst_ack,
	input mips_id_pkg::word_t id_pc,
	input mips_id_pkg::word_t id_inst,
	input logic               id_delay_slot
);

	// fetch is refused while the stage is blocked
	ack_blocked: assert property (@(posedge clk) (stall || clear || !rst_n) |-> !cache_inst_ack)
		else $error("fetch acknowledged during stall, clear or reset");

	clear_loads_reset_pc: assert property (@(posedge clk) (clear || !rst_n) |=> id_pc == RESET_PC)
		else $error("id_pc is not the reset vector after clear or reset");

	stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
		(stall && !clear) |=> $stable(id_pc) && $stable(id_inst) && $stable(id_delay_slot))
		else $error("pipeline register changed during a stall");

endmodule

bind id_stage id_stage_assertions #(
	.RESET_PC (RESET_PC)
) u_assertions (
	.clk            (clk),
	.rst_n          (rst_n),
	.stall          (stall),
	.clear          (clear),
	.cache_inst_ack (cache_inst_ack),
	.id_pc          (id_pc),
	.id_inst        (id_inst),
	.id_delay_slot  (id_delay_slot)
);

// File: dv/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;

	localparam mips_id_pkg::word_t RESET_PC = 32'hbfc0_0000;
	localparam int CLK_PERIOD  = 40;
	localparam int NUM_TESTS   = 6;
	localparam int TEST_CYCLES = 200; // watchdog budget per test

	logic                   clk, rst_n;
	logic                   stall, clear, if_delay_slot, cache_inst_valid, cache_inst_ack;
	mips_id_pkg::word_t     if_pc, cache_inst;
	mips_id_pkg::reg_addr_t reg_raddr1, reg_raddr2;
	mips_id_pkg::word_t     reg_rdata1, reg_rdata2;
	mips_id_pkg::word_t     id_pc, id_inst;
	logic                   id_delay_slot;
	mips_id_pkg::alu_op_t   alu_op;
	mips_id_pkg::reg_addr_t dest;
	mips_id_pkg::mem_size_t mem_size;
	logic                   is_unsigned, is_mult, is_div, is_load, is_store, load_unsigned;
	logic                   branch, br_eq, br_ne, br_gtz_or_gez, br_eq_zero, br_ltz_or_lez;
	logic                   jump, jump_reg, delay, mthi, mtlo, syscall, brk;
	logic                   no_inst, go_mem, go_wb;
	mips_id_pkg::word_t     vsrc1, vsrc2, jr_target;
	logic [25:0]            j_index;

	mips_id_pkg::word_t reg_table [32];
	logic [31:0]        rng;
	mips_id_pkg::word_t next_pc;
	string              test_name;

	tb_clock_gen #(
		.PERIOD       (CLK_PERIOD),
		.RESET_CYCLES (2)
	) u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	id_stage #(
		.RESET_PC (RESET_PC)
	) UUT (.*);

	// register file model
	assign reg_rdata1 = reg_table[reg_raddr1];
	assign reg_rdata2 = reg_table[reg_raddr2];

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic mips_id_pkg::word_t r_word(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, sa, fn};
	endfunction

	function automatic mips_id_pkg::word_t i_word(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mips_id_pkg::word_t j_word(input logic [5:0] op, input logic [25:0] idx);
		return {op, idx};
	endfunction

	function automatic logic known_opcode(input logic [5:0] op);
		case (op)
			mips_id_pkg::OP_SPECIAL, mips_id_pkg::OP_REGIMM, mips_id_pkg::OP_J,
			mips_id_pkg::OP_JAL, mips_id_pkg::OP_BEQ, mips_id_pkg::OP_BNE,
			mips_id_pkg::OP_BLEZ, mips_id_pkg::OP_BGTZ, mips_id_pkg::OP_ADDI,
			mips_id_pkg::OP_ADDIU, mips_id_pkg::OP_SLTI, mips_id_pkg::OP_SLTIU,
			mips_id_pkg::OP_ANDI, mips_id_pkg::OP_ORI, mips_id_pkg::OP_XORI,
			mips_id_pkg::OP_LUI, mips_id_pkg::OP_LB, mips_id_pkg::OP_LH,
			mips_id_pkg::OP_LW, mips_id_pkg::OP_LBU, mips_id_pkg::OP_LHU,
			mips_id_pkg::OP_SB, mips_id_pkg::OP_SH, mips_id_pkg::OP_SW: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("Mismatch in %s: %s expected %h actual %h", test_name, what, exp, act);
			$display("Verification failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	// called 1 ns after an edge, returns 1 ns after the next one
	task automatic step(input mips_id_pkg::word_t word, input mips_id_pkg::word_t pc,
			input logic ds, input logic valid, input logic stl, input logic clr);
		cache_inst       = word;
		if_pc            = pc;
		if_delay_slot    = ds;
		cache_inst_valid = valid;
		stall            = stl;
		clear            = clr;
		@(posedge clk);
		#1;
	endtask

	task automatic issue(input mips_id_pkg::word_t word, input logic ds);
		step(word, next_pc, ds, 1'b1, 1'b0, 1'b0);
		expect_eq("id_inst", word, id_inst);
		expect_eq("id_pc", next_pc, id_pc);
		expect_eq("id_delay_slot", 32'(ds), 32'(id_delay_slot));
		next_pc = next_pc + 32'd4;
	endtask

	task automatic r_case(input logic [5:0] fn, input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [4:0] sa);
		mips_id_pkg::word_t exp1;
		issue(r_word(rs, rt, rd, sa, fn), 1'b0);
		exp1 = (fn == mips_id_pkg::FN_SLL) ? {27'd0, sa} : reg_table[rs];
		expect_eq("dest", 32'(rd), 32'(dest));
		expect_eq("alu_op", 32'(fn), 32'(alu_op));
		expect_eq("reg_raddr1", 32'(rs), 32'(reg_raddr1));
		expect_eq("reg_raddr2", 32'(rt), 32'(reg_raddr2));
		expect_eq("vsrc1", exp1, vsrc1);
		expect_eq("vsrc2", reg_table[rt], vsrc2);
		expect_eq("is_unsigned", 32'(fn == mips_id_pkg::FN_ADDU), 32'(is_unsigned));
		expect_eq("go_wb", 32'd1, 32'(go_wb));
		expect_eq("no_inst", 32'd0, 32'(no_inst));
	endtask

	// flag order is mult div mthi mtlo syscall brk
	task automatic special_case(input logic [5:0] fn, input logic [5:0] flags);
		logic port1;
		port1 = !(flags[1] || flags[0]); // syscall and break read no register
		issue(r_word(5'd2, 5'd0, 5'd0, 5'd0, fn), 1'b0);
		expect_eq("is_mult", 32'(flags[5]), 32'(is_mult));
		expect_eq("is_div", 32'(flags[4]), 32'(is_div));
		expect_eq("mthi", 32'(flags[3]), 32'(mthi));
		expect_eq("mtlo", 32'(flags[2]), 32'(mtlo));
		expect_eq("syscall", 32'(flags[1]), 32'(syscall));
		expect_eq("brk", 32'(flags[0]), 32'(brk));
		expect_eq("reg_raddr1", port1 ? 32'd2 : 32'd0, 32'(reg_raddr1));
		expect_eq("dest", 32'd0, 32'(dest));
		expect_eq("no_inst", 32'd0, 32'(no_inst));
	endtask

	task automatic mem_case(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt,
			input logic [15:0] imm, input logic ld, input mips_id_pkg::mem_size_t size,
			input logic uns);
		issue(i_word(op, rs, rt, imm), 1'b0);
		expect_eq("alu_op", 32'(mips_id_pkg::ALU_ADD), 32'(alu_op));
		expect_eq("dest", ld ? 32'(rt) : 32'd0, 32'(dest));
		expect_eq("mem_size", 32'(size), 32'(mem_size));
		expect_eq("load_unsigned", 32'(uns), 32'(load_unsigned));
		expect_eq("is_load", 32'(ld), 32'(is_load));
		expect_eq("is_store", 32'(!ld), 32'(is_store));
		expect_eq("go_mem", 32'(ld), 32'(go_mem));
		expect_eq("reg_raddr2", ld ? 32'd0 : 32'(rt), 32'(reg_raddr2)); // stores read rt
		expect_eq("vsrc1", reg_table[rs], vsrc1);
		expect_eq("vsrc2", {{16{imm[15]}}, imm}, vsrc2);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	task automatic reset_state();
		test_name = "reset_state";
		#1;
		expect_eq("cache_inst_ack", 32'd0, 32'(cache_inst_ack));
		@(posedge clk);
		#1;
		expect_eq("cache_inst_ack", 32'd0, 32'(cache_inst_ack));
		expect_eq("id_pc", RESET_PC, id_pc);
		expect_eq("id_inst", 32'd0, id_inst);
		expect_eq("delay", 32'd0, 32'(delay));
		expect_eq("go_mem", 32'd0, 32'(go_mem));
		wait (rst_n === 1'b1);
		@(posedge clk);
		#1;
		expect_eq("cache_inst_ack", 32'd1, 32'(cache_inst_ack));
		expect_eq("id_pc", RESET_PC, id_pc); // nothing offered yet
		expect_eq("id_inst", 32'd0, id_inst);
		expect_eq("delay", 32'd0, 32'(delay));
		expect_eq("go_mem", 32'd0, 32'(go_mem));
	endtask

	task automatic r_type_ops();
		test_name = "r_type_ops";
		r_case(mips_id_pkg::FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0);
		r_case(mips_id_pkg::FN_SUB, 5'd4, 5'd5, 5'd6, 5'd0);
		r_case(mips_id_pkg::FN_AND, 5'd7, 5'd8, 5'd9, 5'd0);
		r_case(mips_id_pkg::FN_NOR, 5'd10, 5'd11, 5'd12, 5'd0);
		r_case(mips_id_pkg::FN_SLL, 5'd0, 5'd13, 5'd14, 5'd19); // rs must be zero
		r_case(mips_id_pkg::FN_SRAV, 5'd15, 5'd16, 5'd17, 5'd0);
		special_case(mips_id_pkg::FN_MULT, 6'b100000);
		special_case(mips_id_pkg::FN_DIV, 6'b010000);
		special_case(mips_id_pkg::FN_MTHI, 6'b001000);
		special_case(mips_id_pkg::FN_MTLO, 6'b000100);
		special_case(mips_id_pkg::FN_SYSCALL, 6'b000010);
		special_case(mips_id_pkg::FN_BREAK, 6'b000001);
	endtask

	task automatic imm_and_memory();
		test_name = "imm_and_memory";
		issue(i_word(mips_id_pkg::OP_ADDIU, 5'd3, 5'd7, 16'hfff0), 1'b0);
		expect_eq("alu_op", 32'(mips_id_pkg::OP_ADDIU), 32'(alu_op));
		expect_eq("dest", 32'd7, 32'(dest));
		expect_eq("vsrc1", reg_table[3], vsrc1);
		expect_eq("vsrc2", 32'hffff_fff0, vsrc2);
		expect_eq("reg_raddr2", 32'd0, 32'(reg_raddr2));
		issue(i_word(mips_id_pkg::OP_ORI, 5'd4, 5'd9, 16'h8001), 1'b0);
		expect_eq("alu_op", 32'(mips_id_pkg::OP_ORI), 32'(alu_op));
		expect_eq("dest", 32'd9, 32'(dest));
		expect_eq("vsrc2", 32'h0000_8001, vsrc2); // zero extended
		mem_case(mips_id_pkg::OP_LW, 5'd5, 5'd10, 16'h8004, 1'b1, mips_id_pkg::MEM_WORD, 1'b0);
		mem_case(mips_id_pkg::OP_LBU, 5'd18, 5'd20, 16'h0011, 1'b1, mips_id_pkg::MEM_BYTE, 1'b1);
		mem_case(mips_id_pkg::OP_SH, 5'd6, 5'd11, 16'hff02, 1'b0, mips_id_pkg::MEM_HALF, 1'b0);
	endtask

	task automatic branch_jump();
		mips_id_pkg::word_t pc;
		test_name = "branch_jump";
		issue(i_word(mips_id_pkg::OP_BEQ, 5'd1, 5'd2, 16'h0010), 1'b0);
		expect_eq("br_eq", 32'd1, 32'(br_eq));
		expect_eq("br_ne", 32'd0, 32'(br_ne));
		expect_eq("branch", 32'd1, 32'(branch));
		expect_eq("alu_op", 32'(mips_id_pkg::ALU_NONE), 32'(alu_op));
		expect_eq("vsrc1", reg_table[1], vsrc1);
		expect_eq("vsrc2", reg_table[2], vsrc2); // registers compared
		expect_eq("delay", 32'd1, 32'(delay));
		issue(i_word(mips_id_pkg::OP_BNE, 5'd3, 5'd4, 16'hfff8), 1'b1);
		expect_eq("br_eq", 32'd0, 32'(br_eq));
		expect_eq("br_ne", 32'd1, 32'(br_ne));
		expect_eq("delay", 32'd1, 32'(delay));
		issue(i_word(mips_id_pkg::OP_BLEZ, 5'd5, 5'd0, 16'h0004), 1'b0);
		expect_eq("br_ltz_or_lez", 32'd1, 32'(br_ltz_or_lez));
		expect_eq("br_eq_zero", 32'd1, 32'(br_eq_zero));
		expect_eq("br_gtz_or_gez", 32'd0, 32'(br_gtz_or_gez));
		expect_eq("vsrc1", reg_table[5], vsrc1);
		expect_eq("delay", 32'd1, 32'(delay));
		pc = next_pc;
		issue(i_word(mips_id_pkg::OP_REGIMM, 5'd8, mips_id_pkg::RI_BGEZAL, 16'h0020), 1'b0);
		expect_eq("dest", 32'd31, 32'(dest));
		expect_eq("vsrc1", pc, vsrc1);
		expect_eq("reg_raddr2", 32'd0, 32'(reg_raddr2));
		expect_eq("vsrc2", 32'd8, vsrc2); // return offset
		expect_eq("br_gtz_or_gez", 32'd1, 32'(br_gtz_or_gez));
		expect_eq("br_eq_zero", 32'd1, 32'(br_eq_zero));
		expect_eq("br_ltz_or_lez", 32'd0, 32'(br_ltz_or_lez));
		expect_eq("delay", 32'd1, 32'(delay));
		pc = next_pc;
		issue(j_word(mips_id_pkg::OP_JAL, 26'h2ab_cdef), 1'b1);
		expect_eq("j_index", 32'h02ab_cdef, 32'(j_index));
		expect_eq("dest", 32'd31, 32'(dest));
		expect_eq("vsrc1", pc, vsrc1);
		expect_eq("vsrc2", 32'd8, vsrc2);
		expect_eq("jump", 32'd1, 32'(jump));
		expect_eq("delay", 32'd1, 32'(delay));
		issue(r_word(5'd12, 5'd0, 5'd0, 5'd0, mips_id_pkg::FN_JR), 1'b0);
		expect_eq("jr_target", reg_table[12], jr_target);
		expect_eq("alu_op", 32'(mips_id_pkg::ALU_ADD), 32'(alu_op));
		expect_eq("jump_reg", 32'd1, 32'(jump_reg));
		expect_eq("dest", 32'd0, 32'(dest));
		expect_eq("delay", 32'd1, 32'(delay));
	endtask

	task automatic stall_clear_valid();
		mips_id_pkg::word_t held, blocked, fresh;
		test_name = "stall_clear_valid";
		held    = r_word(5'd1, 5'd2, 5'd3, 5'd0, mips_id_pkg::FN_ADDU);
		blocked = r_word(5'd4, 5'd5, 5'd6, 5'd0, mips_id_pkg::FN_SUB);
		fresh   = i_word(mips_id_pkg::OP_ORI, 5'd7, 5'd8, 16'h1234);
		issue(held, 1'b1);
		step(blocked, 32'h0000_1000, 1'b0, 1'b1, 1'b1, 1'b0); // stalled
		expect_eq("cache_inst_ack", 32'd0, 32'(cache_inst_ack));
		expect_eq("id_inst", held, id_inst);
		step(blocked, 32'h0000_1000, 1'b0, 1'b0, 1'b0, 1'b0); // not valid
		expect_eq("cache_inst_ack", 32'd1, 32'(cache_inst_ack));
		expect_eq("id_inst", held, id_inst);
		expect_eq("id_delay_slot", 32'd1, 32'(id_delay_slot));
		step(blocked, 32'h0000_1000, 1'b0, 1'b1, 1'b0, 1'b1); // clear wins
		expect_eq("cache_inst_ack", 32'd0, 32'(cache_inst_ack));
		expect_eq("id_pc", RESET_PC, id_pc);
		expect_eq("id_inst", 32'd0, id_inst);
		expect_eq("id_delay_slot", 32'd0, 32'(id_delay_slot));
		issue(fresh, 1'b0);
	endtask

	task automatic illegal_words();
		int                 found;
		mips_id_pkg::word_t word;
		test_name = "illegal_words";
		found = 0;
		while (found < 8) begin
			rng  = xorshift(rng);
			word = rng;
			if (!known_opcode(word[31:26])) begin
				issue(word, 1'b0);
				expect_eq("no_inst", 32'd1, 32'(no_inst));
				expect_eq("go_wb", 32'd0, 32'(go_wb));
				expect_eq("go_mem", 32'd0, 32'(go_mem));
				expect_eq("delay", 32'd0, 32'(delay));
				found++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// run
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int i;
		stall            = 1'b0;
		clear            = 1'b0;
		if_pc            = '0;
		if_delay_slot    = 1'b0;
		cache_inst       = '0;
		cache_inst_valid = 1'b0;
		next_pc          = 32'h0040_0000;
		rng              = 32'd68;
		for (i = 0; i < 32; i++) begin
			rng          = xorshift(rng);
			reg_table[i] = rng;
		end
		reg_table[0] = '0; // r0 reads zero
		reset_state();
		r_type_ops();
		imm_and_memory();
		branch_jump();
		stall_clear_valid();
		illegal_words();
		$display("Verification passed");
		$finish;
	end

	initial begin
		#(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
		$display("Timeout: tests did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: project.f
hw/mips_id_pkg.sv
hw/id_select_if.sv
hw/id_latch.sv
hw/inst_decoder.sv
hw/operand_select.sv
hw/id_stage.sv
dv/tb_clock_gen.sv
dv/id_stage_assertions.sv
dv/id_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := id_stage_tb
FILELIST  := project.f
FLAGS     := --timing --assert
BUILD_DIR := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)
